//--- i2sPkg.sv
/*
 * I2S transmitter shared definitions
 * Serial clock timing, FIFO sizing and the host sample word
 * with its two decodings (one 32-bit channel or a 16-bit pair)
 */

`default_nettype none

package i2sPkg;

    //--------------------------------------------------
    // Serial clock timing
    //--------------------------------------------------

    // audioClk cycles per BCLK half period
    localparam logic [2:0] bclkHalfPeriod = 3'd4;

    // Bits per channel slot, MSB first on the line
    localparam logic [5:0] slotBits = 6'd32;

    // BCLK periods per stereo frame (left + right)
    localparam logic [6:0] frameBclks = 7'd64;

    //--------------------------------------------------
    // Sample FIFO sizing
    //--------------------------------------------------

    localparam logic [3:0] fifoDepth = 4'd8;

    // Pointer width, depth must stay a power of two
    localparam logic [1:0] fifoAddrWidth = 2'd3;

    //--------------------------------------------------
    // Host sample word
    //--------------------------------------------------

    // 16-bit packed stereo view
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } samplePair_s;

    // Same 32 bits, read as one channel or as a pair
    typedef union packed {
        logic [31:0] word;
        samplePair_s pair;
    } sampleWord_u;

endpackage

`default_nettype wire

//--- sampleFifo.sv
/*
 * Sample FIFO
 * Eight-entry synchronous buffer for host sample words.
 * Head entry is always visible on rdData, a pop removes it
 * at the next edge. Writes while full are dropped.
 */

`timescale 1ns/10ps
`default_nettype none

module sampleFifo (
    input  wire                 audioClk,
    input  wire                 arstN,
    input  wire                 wrEn,
    input  i2sPkg::sampleWord_u wrData,
    input  wire                 popEn,
    output i2sPkg::sampleWord_u rdData,
    output logic                empty,
    output logic                full
);

    //--------------------------------------------------
    // Storage and pointers
    //--------------------------------------------------

    // Payload only, no reset
    i2sPkg::sampleWord_u mem [0:i2sPkg::fifoDepth-1];

    logic [i2sPkg::fifoAddrWidth-1:0] wrPtr;
    logic [i2sPkg::fifoAddrWidth-1:0] rdPtr;

    // Occupancy, 0 up to fifoDepth inclusive
    logic [3:0] count;

    logic doWrite;
    logic doPop;

    // Qualified requests
    assign doWrite = wrEn && !full;
    assign doPop   = popEn && !empty;

    // Levels straight from the count
    assign empty = (count == 4'd0);
    assign full  = (count == i2sPkg::fifoDepth);

    // Head of queue, always valid when not empty
    assign rdData = mem[rdPtr];

    //--------------------------------------------------
    // Write side
    //--------------------------------------------------

    always_ff @(posedge audioClk)
    begin
        if (doWrite)
        begin
            mem[wrPtr] <= wrData;
        end
    end

    //--------------------------------------------------
    // Pointer and count update
    //--------------------------------------------------

    always_ff @(posedge audioClk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= 4'd0;
        end
        else
        begin
            // Pointers wrap at depth, power of two
            if (doWrite)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end

            // Simultaneous write and pop leaves count alone
            if (doWrite && !doPop)
            begin
                count <= count + 4'd1;
            end
            else if (doPop && !doWrite)
            begin
                count <= count - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- slotLoader.sv
/*
 * Slot loader
 * On each frame request, hands the staged pair to the serializer
 * and refills the stage from the FIFO. Packed mode takes one word
 * for both channels, 32-bit mode one word per channel.
 * A frame without enough data is sent as zeros and flags underrun.
 */

`timescale 1ns/10ps
`default_nettype none

module slotLoader (
    input  wire                         audioClk,
    input  wire                         arstN,
    input  wire                         frameReq,
    input  wire                         packed16,
    input  wire                         clearUnderrun,
    input  i2sPkg::sampleWord_u         rdData,
    input  wire                         empty,
    output logic                        popEn,
    output logic [i2sPkg::slotBits-1:0] leftSlot,
    output logic [i2sPkg::slotBits-1:0] rightSlot,
    output logic                        underrun
);

    // Next frame's pair, one frame ahead of the outputs
    logic [i2sPkg::slotBits-1:0] stageLeft;
    logic [i2sPkg::slotBits-1:0] stageRight;

    // Left word already taken while its right partner is missing
    i2sPkg::sampleWord_u heldWord;
    logic                heldValid;
    i2sPkg::sampleWord_u firstWord;

    // Refill in progress after a request
    logic active;
    logic finish;
    logic fail;

    assign firstWord = heldValid ? heldWord : rdData;

    //--------------------------------------------------
    // Pop decision, one step per cycle
    //--------------------------------------------------

    always_comb
    begin
        popEn  = 1'b0;
        finish = 1'b0;
        fail   = 1'b0;
        if (active)
        begin
            if (packed16)
            begin
                // Single word covers both channels
                finish = 1'b1;
                popEn  = !heldValid && !empty;
                fail   = !heldValid && empty;
            end
            else if (heldValid)
            begin
                // Left in hand, right from FIFO
                finish = 1'b1;
                popEn  = !empty;
                fail   = empty;
            end
            else
            begin
                // Take left now, right next cycle
                popEn  = !empty;
                finish = empty;
                fail   = empty;
            end
        end
    end

    always_ff @(posedge audioClk)
    begin
        if (popEn && !finish)
        begin
            heldWord <= rdData;
        end
    end

    //--------------------------------------------------
    // Stage, outputs and sticky underrun
    //--------------------------------------------------

    always_ff @(posedge audioClk or negedge arstN)
    begin
        if (!arstN)
        begin
            leftSlot   <= '0;
            rightSlot  <= '0;
            stageLeft  <= '0;
            stageRight <= '0;
            active     <= 1'b0;
            heldValid  <= 1'b0;
            underrun   <= 1'b0;
        end
        else
        begin
            // Handover, stable until the next request
            if (frameReq)
            begin
                leftSlot  <= stageLeft;
                rightSlot <= stageRight;
            end

            if (frameReq)
            begin
                active <= 1'b1;
            end
            else if (finish)
            begin
                active <= 1'b0;
            end

            if (finish && fail)
            begin
                stageLeft  <= '0;
                stageRight <= '0;
            end
            else if (finish && packed16)
            begin
                // MSB-justified halves, low bits zero
                stageLeft  <= {firstWord.pair.left, 16'h0000};
                stageRight <= {firstWord.pair.right, 16'h0000};
            end
            else if (finish)
            begin
                stageLeft  <= heldWord.word;
                stageRight <= rdData.word;
            end

            if (finish && !fail)
            begin
                heldValid <= 1'b0;
            end
            else if (popEn)
            begin
                heldValid <= 1'b1;
            end

            // Set wins over a clear in the same cycle
            if (fail)
            begin
                underrun <= 1'b1;
            end
            else if (clearUnderrun)
            begin
                underrun <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- i2sSerializer.sv
/*
 * I2S serializer
 * Divides audioClk into BCLK and LRCLK and shifts each slot out
 * MSB first on falling BCLK edges, one bit period after every
 * LRCLK edge. Pulses frameReq where LRCLK falls.
 */

`timescale 1ns/10ps
`default_nettype none

module i2sSerializer (
    input  wire                         audioClk,
    input  wire                         arstN,
    input  wire [i2sPkg::slotBits-1:0]  leftSlot,
    input  wire [i2sPkg::slotBits-1:0]  rightSlot,
    output logic                        bclk,
    output logic                        lrclk,      // Low left, high right
    output logic                        sdata,
    output logic                        frameReq
);

    //--------------------------------------------------
    // BCLK divider
    //--------------------------------------------------

    logic [2:0] halfCnt;
    logic       bclkToggle;
    logic       bclkFall;

    // Toggle every bclkHalfPeriod cycles
    assign bclkToggle = (halfCnt == i2sPkg::bclkHalfPeriod - 3'd1);

    // Toggle while high means BCLK is about to fall
    assign bclkFall = bclkToggle && bclk;

    always_ff @(posedge audioClk or negedge arstN)
    begin
        if (!arstN)
        begin
            halfCnt <= 3'd0;
            bclk    <= 1'b0;
        end
        else if (bclkToggle)
        begin
            halfCnt <= 3'd0;
            bclk    <= ~bclk;
        end
        else
        begin
            halfCnt <= halfCnt + 3'd1;
        end
    end

    //--------------------------------------------------
    // LRCLK from a count of BCLK half periods
    //--------------------------------------------------

    // 0..127 over one frame, odd values end on a falling edge
    logic [6:0] halfIdx;
    logic       slotEnd;
    logic       frameEnd;
    logic       slotStart;

    // Last half period of a slot and of the frame
    assign slotEnd  = bclkToggle && (halfIdx[5:0] == 6'(2 * i2sPkg::slotBits - 1));
    assign frameEnd = bclkToggle && (halfIdx == 7'(2 * i2sPkg::frameBclks - 1));

    // First falling edge after the LRCLK edge, MSB goes out here
    assign slotStart = bclkFall && (halfIdx[5:1] == 5'd0);

    always_ff @(posedge audioClk or negedge arstN)
    begin
        if (!arstN)
        begin
            halfIdx  <= 7'd0;
            lrclk    <= 1'b0;
            frameReq <= 1'b0;
        end
        else
        begin
            if (frameEnd)
            begin
                halfIdx <= 7'd0;
            end
            else if (bclkToggle)
            begin
                halfIdx <= halfIdx + 7'd1;
            end

            // LRCLK edges always land on a falling BCLK edge
            if (slotEnd)
            begin
                lrclk <= ~lrclk;
            end

            // High in the first cycle with LRCLK low again
            frameReq <= frameEnd;
        end
    end

    //--------------------------------------------------
    // Parallel to serial, MSB first
    //--------------------------------------------------

    logic [i2sPkg::slotBits-1:0] shiftReg;
    logic [i2sPkg::slotBits-1:0] curSlot;

    // LRCLK already switched when the slot starts
    assign curSlot = lrclk ? rightSlot : leftSlot;

    always_ff @(posedge audioClk)
    begin
        if (slotStart)
        begin
            shiftReg <= curSlot << 1;
        end
        else if (bclkFall)
        begin
            shiftReg <= shiftReg << 1;
        end
    end

    // LSB of the old slot stays on through the LRCLK edge period
    always_ff @(posedge audioClk or negedge arstN)
    begin
        if (!arstN)
        begin
            sdata <= 1'b0;
        end
        else if (slotStart)
        begin
            sdata <= curSlot[i2sPkg::slotBits-1];
        end
        else if (bclkFall)
        begin
            sdata <= shiftReg[i2sPkg::slotBits-1];
        end
    end

endmodule

`default_nettype wire

//--- i2sTransmitter.sv
/*
 * Stereo I2S transmitter
 * Host words go through the sample FIFO, the loader turns them
 * into left/right slots once per frame, the serializer drives
 * the I2S pins
 */

`timescale 1ns/10ps
`default_nettype none

module i2sTransmitter (
    input  wire        audioClk,
    input  wire        arstN,
    input  wire        wrEn,
    input  wire [31:0] wrData,
    input  wire        packed16,
    input  wire        clearUnderrun,
    output logic       bclk,
    output logic       lrclk,
    output logic       sdata,
    output logic       fifoFull,
    output logic       underrun
);

    // FIFO to loader
    i2sPkg::sampleWord_u rdData;
    logic                empty;
    logic                popEn;

    // Serializer and loader
    logic                        frameReq;
    logic [i2sPkg::slotBits-1:0] leftSlot;
    logic [i2sPkg::slotBits-1:0] rightSlot;

    sampleFifo fifoInst (
        .audioClk (audioClk),
        .arstN    (arstN),
        .wrEn     (wrEn),
        .wrData   (wrData),
        .popEn    (popEn),
        .rdData   (rdData),
        .empty    (empty),
        .full     (fifoFull)
    );

    slotLoader loaderInst (
        .audioClk      (audioClk),
        .arstN         (arstN),
        .frameReq      (frameReq),
        .packed16      (packed16),
        .clearUnderrun (clearUnderrun),
        .rdData        (rdData),
        .empty         (empty),
        .popEn         (popEn),
        .leftSlot      (leftSlot),
        .rightSlot     (rightSlot),
        .underrun      (underrun)
    );

    i2sSerializer serInst (
        .audioClk  (audioClk),
        .arstN     (arstN),
        .leftSlot  (leftSlot),
        .rightSlot (rightSlot),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .sdata     (sdata),
        .frameReq  (frameReq)
    );

endmodule

`default_nettype wire

//--- i2sTransmitter_properties.sv
/*
 * I2S pin properties
 * Clock and data edges on the I2S pins, and fifoFull rising
 * only after a host write. Bound to the transmitter top level.
 */

`timescale 1ns/10ps
`default_nettype none

module i2sTransmitter_properties (
    input wire audioClk,
    input wire arstN,
    input wire bclk,
    input wire lrclk,
    input wire sdata,
    input wire wrEn,
    input wire fifoFull
);

    // LRCLK edges sit on falling BCLK edges
    property lrclkOnBclkFall;
        @(posedge audioClk) disable iff (!arstN)
        $changed(lrclk) |-> $fell(bclk);
    endproperty

    // Data stable around rising BCLK
    property sdataOnBclkFall;
        @(posedge audioClk) disable iff (!arstN)
        $changed(sdata) |-> $fell(bclk);
    endproperty

    // Count only grows on a write
    property fullAfterWrite;
        @(posedge audioClk) disable iff (!arstN)
        $rose(fifoFull) |-> $past(wrEn);
    endproperty

    lrclkEdge: assert property (lrclkOnBclkFall)
        else $error("lrclk changed outside a falling bclk edge");

    sdataEdge: assert property (sdataOnBclkFall)
        else $error("sdata changed outside a falling bclk edge");

    fullRise: assert property (fullAfterWrite)
        else $error("fifoFull rose without a host write");

endmodule

bind i2sTransmitter i2sTransmitter_properties propsInst (
    .audioClk (audioClk),
    .arstN    (arstN),
    .bclk     (bclk),
    .lrclk    (lrclk),
    .sdata    (sdata),
    .wrEn     (wrEn),
    .fifoFull (fifoFull)
);

`default_nettype wire

//--- tb_i2sTransmitter.sv
/*
 * I2S transmitter testbench
 * Directed tests for reset, clock ratios, 32-bit and packed frames,
 * FIFO overflow and underrun recovery. A frame decoder on the I2S
 * pins rebuilds left/right words for the checks.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_i2sTransmitter;

    logic        audioClk = 1'b0;
    logic        arstN;
    logic        wrEn;
    logic [31:0] wrData;
    logic        packed16;
    logic        clearUnderrun;
    wire         bclk;
    wire         lrclk;
    wire         sdata;
    wire         fifoFull;
    wire         underrun;

    // Decoded frames, left word in the upper half
    logic [63:0] frames [$];
    logic [31:0] words [0:15];
    logic [31:0] rngState = 32'd5;
    int          cycleCount = 0;

    // Decoder state
    logic        bclkPrev;
    logic        lrPrev;
    logic [31:0] shiftAcc;
    logic [31:0] leftWord;

    i2sTransmitter UUT (
        .audioClk      (audioClk),
        .arstN         (arstN),
        .wrEn          (wrEn),
        .wrData        (wrData),
        .packed16      (packed16),
        .clearUnderrun (clearUnderrun),
        .bclk          (bclk),
        .lrclk         (lrclk),
        .sdata         (sdata),
        .fifoFull      (fifoFull),
        .underrun      (underrun)
    );

    // 8 ns audio clock
    always #4 audioClk = ~audioClk;

    //--------------------------------------------------
    // Run limit
    //--------------------------------------------------

    // About 31 frames of tests (ratios 3, stereo 7, packed 7,
    // overflow 8, underrun 6), rounded up to 36 plus margin
    always @(posedge audioClk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount == 36 * 2 * i2sPkg::bclkHalfPeriod * i2sPkg::frameBclks + 1000)
            failRun("Timeout: tests did not finish within the cycle limit");
    end

    //--------------------------------------------------
    // I2S frame decoder, sampled mid-cycle
    //--------------------------------------------------

    always @(negedge audioClk)
    begin
        if (!arstN)
        begin
            bclkPrev = 1'b0;
            lrPrev   = 1'b0;
            shiftAcc = '0;
            leftWord = '0;
        end
        else
        begin
            if (bclk && !bclkPrev)
            begin
                // Bit after an LRCLK edge is the LSB of the slot just ended
                shiftAcc = {shiftAcc[30:0], sdata};
                if (lrclk != lrPrev && lrPrev)
                    frames.push_back({leftWord, shiftAcc});
                else if (lrclk != lrPrev)
                    leftWord = shiftAcc;
                lrPrev = lrclk;
            end
            bclkPrev = bclk;
        end
    end

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------

    task automatic failRun(input string reason);
        begin
            $display("%s", reason);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        begin
            if (actual !== expected)
                failRun($sformatf("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual));
        end
    endtask

    task automatic checkIdlePins();
        begin
            checkValue("bclk", 0, bclk);
            checkValue("lrclk", 0, lrclk);
            checkValue("sdata", 0, sdata);
            checkValue("fifoFull", 0, fifoFull);
            checkValue("underrun", 0, underrun);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        begin
            s = x ^ (x << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
            return s;
        end
    endfunction

    // MSB forced high, so no data frame decodes as idle
    task automatic fillWords(input int count);
        begin
            for (int i = 0; i < count; i++)
            begin
                rngState = xorshift32(rngState);
                words[i] = rngState | 32'h8000_0000;
            end
        end
    endtask

    task automatic writeWords(input int count);
        begin
            for (int i = 0; i < count; i++)
            begin
                @(posedge audioClk);
                wrEn   <= 1'b1;
                wrData <= words[i];
            end
            @(posedge audioClk);
            wrEn <= 1'b0;
        end
    endtask

    // Next edge of lrclk/bclk towards the given level
    task automatic waitLrclk(input logic level);
        begin
            do @(negedge audioClk); while (lrclk == level);
            do @(negedge audioClk); while (lrclk != level);
        end
    endtask

    task automatic waitBclk(input logic level);
        begin
            do @(negedge audioClk); while (bclk == level);
            do @(negedge audioClk); while (bclk != level);
        end
    endtask

    // Drop idle frames ahead of the data, then wait for count frames
    task automatic alignFrames(input int count);
        begin
            while (frames.size() < count || frames[0] == 64'h0)
            begin
                if (frames.size() > 0 && frames[0] == 64'h0)
                    void'(frames.pop_front());
                else
                    @(negedge audioClk);
            end
        end
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------

    task automatic resetState();
        begin
            repeat (5) @(posedge audioClk);
            @(negedge audioClk);
            checkIdlePins();
            repeat (5) @(posedge audioClk);
            arstN <= 1'b1;
            @(negedge audioClk);
            checkIdlePins();
        end
    endtask

    task automatic clockRatios();
        int start;
        int bclkPeriod;
        begin
            waitBclk(1'b1);
            start = cycleCount;
            waitBclk(1'b1);
            bclkPeriod = cycleCount - start;
            checkValue("bclk period", 2 * i2sPkg::bclkHalfPeriod, bclkPeriod);
            waitLrclk(1'b0);
            start = cycleCount;
            waitLrclk(1'b0);
            checkValue("lrclk period", 2 * i2sPkg::bclkHalfPeriod * i2sPkg::frameBclks,
                       cycleCount - start);
        end
    endtask

    task automatic stereoFrames();
        begin
            fillWords(8);
            waitLrclk(1'b1);
            frames.delete();
            writeWords(8);
            alignFrames(4);
            // One word per channel, left first
            for (int i = 0; i < 4; i++)
            begin
                checkValue("left slot", words[2 * i], frames[i][63:32]);
                checkValue("right slot", words[2 * i + 1], frames[i][31:0]);
            end
        end
    endtask

    task automatic packedFrames();
        begin
            fillWords(4);
            waitLrclk(1'b1);
            @(posedge audioClk);
            packed16 <= 1'b1;
            frames.delete();
            writeWords(4);
            alignFrames(4);
            // Halves MSB-justified, 16 zero bits below
            for (int i = 0; i < 4; i++)
            begin
                checkValue("left slot", {words[i][31:16], 16'h0}, frames[i][63:32]);
                checkValue("right slot", {words[i][15:0], 16'h0}, frames[i][31:0]);
            end
        end
    endtask

    task automatic fifoOverflow();
        begin
            fillWords(10);
            waitLrclk(1'b1);
            @(posedge audioClk);
            packed16 <= 1'b0;
            frames.delete();
            for (int i = 0; i < 10; i++)
            begin
                @(posedge audioClk);
                wrEn   <= 1'b1;
                wrData <= words[i];
                // i words stored by now, full at depth
                @(negedge audioClk);
                checkValue("fifoFull", i >= i2sPkg::fifoDepth, fifoFull);
            end
            @(posedge audioClk);
            wrEn <= 1'b0;
            alignFrames(5);
            for (int i = 0; i < 4; i++)
            begin
                checkValue("left slot", words[2 * i], frames[i][63:32]);
                checkValue("right slot", words[2 * i + 1], frames[i][31:0]);
            end
            // Words 8 and 9 were dropped
            checkValue("frame after overflow", 0, frames[4]);
            checkValue("fifoFull", 0, fifoFull);
        end
    endtask

    task automatic underrunRecovery();
        begin
            // Start from a cleared flag so the next empty request must set it
            @(posedge audioClk);
            clearUnderrun <= 1'b1;
            @(posedge audioClk);
            clearUnderrun <= 1'b0;
            @(negedge audioClk);
            checkValue("underrun", 0, underrun);
            waitLrclk(1'b0);
            waitLrclk(1'b1);
            checkValue("underrun", 1, underrun);
            checkValue("idle frame", 0, frames[frames.size() - 1]);
            fillWords(4);
            frames.delete();
            writeWords(4);
            @(posedge audioClk);
            clearUnderrun <= 1'b1;
            @(posedge audioClk);
            clearUnderrun <= 1'b0;
            @(negedge audioClk);
            checkValue("underrun", 0, underrun);
            // Two refills find both words each
            repeat (2)
            begin
                waitLrclk(1'b0);
                waitLrclk(1'b1);
                checkValue("underrun", 0, underrun);
            end
            alignFrames(2);
            for (int i = 0; i < 2; i++)
            begin
                checkValue("left slot", words[2 * i], frames[i][63:32]);
                checkValue("right slot", words[2 * i + 1], frames[i][31:0]);
            end
            // Third request found the FIFO drained
            checkValue("underrun", 1, underrun);
        end
    endtask

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------

    initial
    begin
        arstN         = 1'b0;
        wrEn          = 1'b0;
        wrData        = '0;
        packed16      = 1'b0;
        clearUnderrun = 1'b0;
        resetState();
        clockRatios();
        stereoFrames();
        packedFrames();
        fifoOverflow();
        underrunRecovery();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
i2sPkg.sv
sampleFifo.sv
slotLoader.sv
i2sSerializer.sv
i2sTransmitter.sv
i2sTransmitter_properties.sv
tb_i2sTransmitter.sv

//--- Bender.yml
package:
  name: i2s_transmitter

sources:
  - i2sPkg.sv
  - sampleFifo.sv
  - slotLoader.sv
  - i2sSerializer.sv
  - i2sTransmitter.sv
  - target: test
    files:
      - i2sTransmitter_properties.sv
      - tb_i2sTransmitter.sv
